// File: src/cache_pkg.sv
// Cache geometry, address field types, bus and way structs, controller states.
package cache_pkg;

    // Geometry.
    localparam int ADDR_W         = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_SETS       = 8;
    localparam int NUM_WAYS       = 2;

    // Address fields, from the top: tag, set, word offset, byte.
    localparam int WORD_OFS_W = $clog2(WORDS_PER_LINE);
    localparam int SET_W      = $clog2(NUM_SETS);
    localparam int TAG_W      = ADDR_W - SET_W - WORD_OFS_W - 2;

    typedef logic [31:0]                   word_t;
    typedef logic [3:0]                    byte_en_t;
    typedef logic [ADDR_W-1:0]             byte_addr_t;
    typedef logic [TAG_W-1:0]              tag_t;
    typedef logic [SET_W-1:0]              set_idx_t;
    typedef logic [WORD_OFS_W-1:0]         word_ofs_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]   way_idx_t;

    // CPU request; an all-zero byte mask is a read.
    typedef struct packed {
        byte_addr_t addr;
        word_t      data;
        byte_en_t   byte_en;
    } cpu_req_t;

    typedef struct packed {
        word_t data;
    } cpu_rsp_t;

    // External memory request, word addressed.
    typedef struct packed {
        logic [ADDR_W-3:0] addr;
        word_t             data;
        logic              write;
    } mem_req_t;

    // Registered read result of one way.
    typedef struct packed {
        logic  hit;
        logic  valid;
        logic  dirty;
        tag_t  tag;
        word_t data;
    } way_rd_t;

    // Write into one way. The tag, valid and dirty bits only change with tag_we.
    typedef struct packed {
        logic      tag_we;
        tag_t      tag;
        logic      valid;
        logic      dirty;
        byte_en_t  byte_en;
        word_t     data;
        set_idx_t  set;
        word_ofs_t ofs;
    } way_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        FILL,
        FLUSH_SCAN,
        FLUSH_WRITE_BACK
    } ctrl_state_t;

    function automatic tag_t addr_tag(byte_addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic set_idx_t addr_set(byte_addr_t a);
        return a[2+WORD_OFS_W +: SET_W];
    endfunction

    function automatic word_ofs_t addr_ofs(byte_addr_t a);
        return a[2 +: WORD_OFS_W];
    endfunction

endpackage

// File: src/cache_access_buffer.sv
// Access buffer holding the accepted CPU request until the controller retires it.
module cache_access_buffer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                req_valid,
    input  logic                req_ready,
    input  cache_pkg::cpu_req_t req,
    output cache_pkg::cpu_req_t acc_req,
    output logic                acc_valid
);

    // The controller only raises req_ready once the held request is done,
    // so a ready cycle either loads a new request or empties the buffer.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_valid <= 1'b0;
        end else if (req_ready) begin
            acc_valid <= req_valid;
        end
    end

    // Payload only.
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            acc_req <= req;
        end
    end

endmodule

// File: src/cache_way.sv
// One cache way: tag, valid and dirty per set, byte-writable data, tag compare.
module cache_way (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::set_idx_t  rd_set,
    input  cache_pkg::word_ofs_t rd_ofs,
    input  cache_pkg::tag_t      cmp_tag,
    input  cache_pkg::way_wr_t   wr,
    input  logic                wr_en,
    output cache_pkg::way_rd_t   rd
);
    import cache_pkg::*;

    // Storage.
    tag_t                tags [NUM_SETS];
    word_t               data [NUM_SETS][WORDS_PER_LINE];
    logic [NUM_SETS-1:0] valid;
    logic [NUM_SETS-1:0] dirty;

    // Read registers.
    tag_t  tag_q;
    word_t data_q;
    logic  valid_q;
    logic  dirty_q;

    // Line state bits, cleared on reset.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid   <= '0;
            dirty   <= '0;
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else begin
            valid_q <= valid[rd_set];
            dirty_q <= dirty[rd_set];
            if (wr_en && wr.tag_we) begin
                valid[wr.set] <= wr.valid;
                dirty[wr.set] <= wr.dirty;
            end
        end
    end

    // Tag and data arrays, read before write.
    always_ff @(posedge clk) begin
        tag_q  <= tags[rd_set];
        data_q <= data[rd_set][rd_ofs];
        if (wr_en && wr.tag_we) begin
            tags[wr.set] <= wr.tag;
        end
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.byte_en[b]) begin
                    data[wr.set][wr.ofs][b*8 +: 8] <= wr.data[b*8 +: 8];
                end
            end
        end
    end

    // Hit against the current request tag.
    assign rd.hit   = valid_q && (tag_q == cmp_tag);
    assign rd.valid = valid_q;
    assign rd.dirty = dirty_q;
    assign rd.tag   = tag_q;
    assign rd.data  = data_q;

endmodule

// File: src/cache_way_select.sv
// Way select: hit encoding, hit word and victim line information.
module cache_way_select (
    input  cache_pkg::way_rd_t  way_rd [cache_pkg::NUM_WAYS],
    input  cache_pkg::way_idx_t victim_way,
    output logic                hit,
    output cache_pkg::way_idx_t hit_way,
    output cache_pkg::word_t    hit_data,
    output logic                victim_dirty,
    output cache_pkg::tag_t     victim_tag,
    output cache_pkg::word_t    victim_data
);
    import cache_pkg::*;

    // At most one way can hold a given tag.
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_rd[w].hit) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign hit_data = way_rd[hit_way].data;

    // Only a valid dirty line needs write-back.
    assign victim_dirty = way_rd[victim_way].valid && way_rd[victim_way].dirty;
    assign victim_tag   = way_rd[victim_way].tag;
    assign victim_data  = way_rd[victim_way].data;

endmodule

// File: src/cache_controller.sv
// Cache controller FSM: lookup, write-back, fill, flush, round-robin and memory port.
module cache_controller (
    input  logic                         clk,
    input  logic                         arst_n,
    input  cache_pkg::cpu_req_t          acc_req,
    input  logic                         acc_valid,
    input  logic                         flush,
    input  logic                         hit,
    input  cache_pkg::way_idx_t          hit_way,
    input  cache_pkg::word_t             hit_data,
    input  logic                         victim_dirty,
    input  cache_pkg::tag_t              victim_tag,
    input  cache_pkg::word_t             victim_data,
    output cache_pkg::way_idx_t          victim_way,
    output cache_pkg::set_idx_t          rd_set,
    output cache_pkg::word_ofs_t         rd_ofs,
    output cache_pkg::way_wr_t           wr,
    output logic [cache_pkg::NUM_WAYS-1:0] wr_en,
    output logic                         req_ready,
    output logic                         busy,
    output logic                         rsp_valid,
    output cache_pkg::cpu_rsp_t          rsp,
    output logic                         mem_req_valid,
    input  logic                         mem_ready,
    output cache_pkg::mem_req_t          mem_req,
    input  logic                         mem_rsp_valid,
    input  cache_pkg::word_t             mem_rsp_data
);
    import cache_pkg::*;

    ctrl_state_t state;
    word_ofs_t   cnt;
    logic        rd_pend;
    logic        primed;
    way_idx_t    rr [NUM_SETS];

    // Flush position, set in the upper bits and way in the lower.
    logic [SET_W+$bits(way_idx_t)-1:0] flush_idx;
    set_idx_t scan_set;
    way_idx_t scan_way;

    tag_t      acc_tag;
    set_idx_t  acc_set;
    word_ofs_t acc_ofs;
    set_idx_t  line_set;
    logic      is_read;
    logic      in_flush;
    logic      in_wb;
    logic      mem_fire;
    logic      wb_last;
    logic      rsp_take;
    logic      inv_entry;
    logic      wr_go;
    way_idx_t  wsel;

    assign acc_tag = addr_tag(acc_req.addr);
    assign acc_set = addr_set(acc_req.addr);
    assign acc_ofs = addr_ofs(acc_req.addr);
    assign is_read = (acc_req.byte_en == '0);
    assign {scan_set, scan_way} = flush_idx;

    assign in_flush = state inside {FLUSH_SCAN, FLUSH_WRITE_BACK};
    assign in_wb    = state inside {WRITE_BACK, FLUSH_WRITE_BACK};
    assign mem_fire = mem_req_valid && mem_ready;
    assign wb_last  = in_wb && mem_fire && (&cnt);

    // A zero-delay answer may arrive in the same cycle as the request.
    assign rsp_take = (state == FILL) && mem_rsp_valid && (rd_pend || mem_fire);

    // Clean entries drop during the scan, dirty ones after their write-back.
    assign inv_entry = (state == FLUSH_SCAN && primed && !victim_dirty)
                    || (state == FLUSH_WRITE_BACK && wb_last);

    assign line_set   = in_flush ? scan_set : acc_set;
    assign victim_way = in_flush ? scan_way : rr[acc_set];
    assign rd_set     = line_set;

    // Write-back reads one word ahead so data is ready when memory accepts.
    always_comb begin
        case (state)
            IDLE:                         rd_ofs = acc_ofs;
            WRITE_BACK, FLUSH_WRITE_BACK: rd_ofs = mem_fire ? cnt + 1'b1 : cnt;
            default:                      rd_ofs = '0;
        endcase
    end

    // CPU side.
    assign busy      = in_flush;
    assign req_ready = (state == IDLE && !acc_valid) || (state == LOOKUP && hit);
    assign rsp_valid = (state == LOOKUP) && hit && is_read;
    assign rsp.data  = hit_data;

    // Memory side. Read data field is zero so the request holds steady.
    assign mem_req_valid = in_wb || (state == FILL && !rd_pend);
    assign mem_req.addr  = {in_wb ? victim_tag : acc_tag, line_set, cnt};
    assign mem_req.data  = in_wb ? victim_data : '0;
    assign mem_req.write = in_wb;

    // Way write command.
    always_comb begin
        wr      = '0;
        wr.set  = line_set;
        wr.ofs  = cnt;
        wr.tag  = acc_tag;
        wr_go   = 1'b0;
        wsel    = victim_way;
        if (state == LOOKUP && hit && !is_read) begin
            // Write hit merges bytes and marks the line dirty.
            wr_go      = 1'b1;
            wsel       = hit_way;
            wr.tag_we  = 1'b1;
            wr.valid   = 1'b1;
            wr.dirty   = 1'b1;
            wr.byte_en = acc_req.byte_en;
            wr.data    = acc_req.data;
            wr.ofs     = acc_ofs;
        end else if (rsp_take) begin
            wr_go      = 1'b1;
            wr.tag_we  = 1'b1;
            wr.valid   = 1'b1;
            wr.byte_en = '1;
            wr.data    = mem_rsp_data;
        end else if (inv_entry) begin
            // Clears valid and dirty.
            wr_go     = 1'b1;
            wr.tag_we = 1'b1;
        end
    end

    assign wr_en = NUM_WAYS'(wr_go) << wsel;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            cnt       <= '0;
            rd_pend   <= 1'b0;
            primed    <= 1'b0;
            flush_idx <= '0;
            for (int s = 0; s < NUM_SETS; s++) begin
                rr[s] <= '0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (flush) begin
                        state     <= FLUSH_SCAN;
                        flush_idx <= '0;
                        primed    <= 1'b0;
                    end else if (acc_valid) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        state <= IDLE;
                    end else begin
                        cnt   <= '0;
                        state <= victim_dirty ? WRITE_BACK : FILL;
                    end
                end
                WRITE_BACK, FLUSH_WRITE_BACK: begin
                    if (mem_fire) begin
                        cnt <= cnt + 1'b1;
                    end
                    if (wb_last && state == WRITE_BACK) begin
                        state <= FILL;
                    end else if (wb_last) begin
                        state <= (&flush_idx) ? IDLE : FLUSH_SCAN;
                    end
                end
                FILL: begin
                    if (rsp_take) begin
                        rd_pend <= 1'b0;
                        cnt     <= cnt + 1'b1;
                        if (&cnt) begin
                            // Line complete. Replay the request as a hit.
                            rr[acc_set] <= rr[acc_set] + 1'b1;
                            state       <= IDLE;
                        end
                    end else if (mem_fire) begin
                        rd_pend <= 1'b1;
                    end
                end
                FLUSH_SCAN: begin
                    // One cycle for the entry's line state to be read.
                    if (!primed) begin
                        primed <= 1'b1;
                    end else if (victim_dirty) begin
                        cnt   <= '0;
                        state <= FLUSH_WRITE_BACK;
                    end else if (&flush_idx) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            if (inv_entry) begin
                flush_idx <= flush_idx + 1'b1;
                primed    <= 1'b0;
            end
        end
    end

endmodule

// File: src/cache_top.sv
// Cache top level: access buffer, way array, way select and controller.
module cache_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                req_valid,
    input  cache_pkg::cpu_req_t req,
    output logic                req_ready,
    output logic                busy,
    output logic                rsp_valid,
    output cache_pkg::cpu_rsp_t rsp,
    output logic                mem_req_valid,
    input  logic                mem_ready,
    output cache_pkg::mem_req_t mem_req,
    input  logic                mem_rsp_valid,
    input  cache_pkg::word_t    mem_rsp_data
);
    import cache_pkg::*;

    cpu_req_t             acc_req;
    logic                 acc_valid;
    set_idx_t             rd_set;
    word_ofs_t            rd_ofs;
    tag_t                 cmp_tag;
    way_wr_t              wr;
    logic [NUM_WAYS-1:0]  wr_en;
    way_rd_t              way_rd [NUM_WAYS];
    logic                 hit;
    way_idx_t             hit_way;
    word_t                hit_data;
    way_idx_t             victim_way;
    logic                 victim_dirty;
    tag_t                 victim_tag;
    word_t                victim_data;

    assign cmp_tag = addr_tag(acc_req.addr);

    cache_access_buffer u_access_buffer (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .acc_req   (acc_req),
        .acc_valid (acc_valid)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way u_way (
            .clk     (clk),
            .arst_n  (arst_n),
            .rd_set  (rd_set),
            .rd_ofs  (rd_ofs),
            .cmp_tag (cmp_tag),
            .wr      (wr),
            .wr_en   (wr_en[w]),
            .rd      (way_rd[w])
        );
    end

    cache_way_select u_way_select (
        .way_rd       (way_rd),
        .victim_way   (victim_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_data     (hit_data),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_data  (victim_data)
    );

    cache_controller u_controller (
        .clk           (clk),
        .arst_n        (arst_n),
        .acc_req       (acc_req),
        .acc_valid     (acc_valid),
        .flush         (flush),
        .hit           (hit),
        .hit_way       (hit_way),
        .hit_data      (hit_data),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .victim_data   (victim_data),
        .victim_way    (victim_way),
        .rd_set        (rd_set),
        .rd_ofs        (rd_ofs),
        .wr            (wr),
        .wr_en         (wr_en),
        .req_ready     (req_ready),
        .busy          (busy),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_ready     (mem_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

endmodule

// File: verif/cache_properties.sv
// Handshake assertions for the cache controller, with their bind into the controller.
module cache_properties (
    input logic                   clk,
    input logic                   arst_n,
    input cache_pkg::ctrl_state_t state,
    input logic                   flush,
    input logic                   req_ready,
    input logic                   busy,
    input logic                   rsp_valid,
    input logic                   mem_req_valid,
    input logic                   mem_ready,
    input cache_pkg::mem_req_t    mem_req
);
    import cache_pkg::*;

    // Number of failed assertions.
    int failures = 0;

    // A stalled memory request holds until memory takes it.
    a_mem_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req_valid && !mem_ready) |=> (mem_req_valid && $stable(mem_req)))
        else begin
            $error("mem_req changed while mem_ready was low");
            failures++;
        end

    // A flush taken in IDLE raises busy, and no CPU request is taken while busy.
    a_ready_low_busy: assert property (@(posedge clk) disable iff (!arst_n)
        ($past(flush && state == IDLE) || busy) |-> (busy && !req_ready))
        else begin
            $error("req_ready high or busy low after a flush was taken");
            failures++;
        end

    // Responses rise only in a lookup and last one cycle.
    a_rsp_in_lookup: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> (state == LOOKUP && !$past(rsp_valid)))
        else begin
            $error("rsp_valid high outside LOOKUP or longer than one cycle");
            failures++;
        end

endmodule

bind cache_controller cache_properties u_properties (
    .clk           (clk),
    .arst_n        (arst_n),
    .state         (state),
    .flush         (flush),
    .req_ready     (req_ready),
    .busy          (busy),
    .rsp_valid     (rsp_valid),
    .mem_req_valid (mem_req_valid),
    .mem_ready     (mem_ready),
    .mem_req       (mem_req)
);

// File: verif/cache_tb.sv
// Cache testbench: stimulus table, memory model with random delays, shadow model, checks.
module cache_tb;
    import cache_pkg::*;

    localparam int MEM_WORDS = 2 ** (ADDR_W - 2);
    localparam int TIMEOUT   = 1000;
    localparam logic [1:0] OP_READ  = 2'd0;
    localparam logic [1:0] OP_WRITE = 2'd1;
    localparam logic [1:0] OP_FLUSH = 2'd2;
    localparam int SIG_READY = 0;
    localparam int SIG_RSP   = 1;
    localparam int SIG_BUSY  = 2;

    // One table row; exp_hit marks an access that must hit.
    typedef struct packed {
        logic [1:0] op;
        byte_addr_t addr;
        word_t      data;
        byte_en_t   byte_en;
        logic       exp_hit;
    } stim_t;

    logic     clk = 1'b0;
    logic     arst_n;
    logic     flush;
    logic     req_valid;
    cpu_req_t req;
    logic     req_ready;
    logic     busy;
    logic     rsp_valid;
    cpu_rsp_t rsp;
    logic     mem_req_valid;
    logic     mem_ready;
    mem_req_t mem_req;
    logic     mem_rsp_valid;
    word_t    mem_rsp_data;

    word_t             mem_model [MEM_WORDS];
    word_t             shadow [MEM_WORDS];
    stim_t             stim_q [$];
    logic [15:0]       lfsr_state = 16'd24270;
    int                mem_reads = 0;
    int                rsp_count = 0;
    int                reads_issued = 0;
    int                errors = 0;
    int                timeouts = 0;
    logic              aborted = 1'b0;
    int                rsp_wait = -1;
    logic [ADDR_W-3:0] rsp_addr;

    cache_top dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .busy          (busy),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_ready     (mem_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    always #4 clk = ~clk;

    // Galois LFSR, one step per bit returned.
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        logic       lsb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 16'hB400;
            end
            r = {r[6:0], lsb};
        end
        return r;
    endfunction

    // Memory model. Reads answer 1 to 4 cycles after acceptance.
    always @(posedge clk) begin
        if (!arst_n) begin
            mem_ready     <= 1'b0;
            mem_rsp_valid <= 1'b0;
            rsp_wait = -1;
        end else begin
            mem_rsp_valid <= 1'b0;
            if (rsp_wait == 0) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_data  <= mem_model[rsp_addr];
                rsp_wait = -1;
            end else if (rsp_wait > 0) begin
                rsp_wait = rsp_wait - 1;
            end
            if (mem_req_valid && mem_ready) begin
                if (mem_req.write) begin
                    mem_model[mem_req.addr] <= mem_req.data;
                end else begin
                    if (rsp_wait >= 0) begin
                        $display("Memory read accepted while another read was outstanding");
                        errors++;
                    end
                    rsp_addr = mem_req.addr;
                    rsp_wait = int'(rand_bits(2));
                    mem_reads <= mem_reads + 1;
                end
            end
            mem_ready <= (rand_bits(2) != 2'b00);
        end
    end

    always @(posedge clk) begin
        if (arst_n && rsp_valid) begin
            rsp_count <= rsp_count + 1;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
    endtask

    // Counts rising edges until the chosen signal is sampled at the wanted level.
    task automatic wait_signal(input int sig, input logic level, input string name,
                               output int cycles);
        logic value;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && !aborted) begin
            @(posedge clk);
            cycles++;
            case (sig)
                SIG_READY: value = req_ready;
                SIG_RSP:   value = rsp_valid;
                default:   value = busy;
            endcase
            seen = (value === level);
            if (!seen && cycles >= TIMEOUT) begin
                $display("Timeout: %s did not reach %b within %0d cycles", name, level, TIMEOUT);
                timeouts++;
                aborted = 1'b1;
            end
        end
    endtask

    function automatic stim_t make_stim(input logic [1:0] op, input byte_addr_t addr,
                                        input word_t data, input byte_en_t be, input logic hit);
        stim_t s;
        s.op      = op;
        s.addr    = addr;
        s.data    = data;
        s.byte_en = be;
        s.exp_hit = hit;
        return s;
    endfunction

    task automatic access_and_check(input stim_t s);
        int    cycles;
        int    reads_before;
        word_t expected;
        req_valid   <= 1'b1;
        req.addr    <= s.addr;
        req.data    <= s.data;
        req.byte_en <= (s.op == OP_READ) ? 4'h0 : s.byte_en;
        wait_signal(SIG_READY, 1'b1, "req_ready", cycles);
        req_valid <= 1'b0;
        reads_before = mem_reads;
        if (s.op == OP_READ) begin
            reads_issued++;
            wait_signal(SIG_RSP, 1'b1, "rsp_valid", cycles);
            expected = shadow[s.addr[ADDR_W-1:2]];
            if (!aborted && rsp.data !== expected) begin
                report_mismatch("rsp.data", expected, rsp.data);
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (s.byte_en[b]) begin
                    shadow[s.addr[ADDR_W-1:2]][b*8 +: 8] = s.data[b*8 +: 8];
                end
            end
            wait_signal(SIG_READY, 1'b1, "req_ready after write", cycles);
        end
        if (!aborted && s.exp_hit) begin
            if (cycles != 2) begin
                report_mismatch("hit latency", 2, cycles);
            end
            if (mem_reads != reads_before) begin
                report_mismatch("memory reads on hit", 0, mem_reads - reads_before);
            end
        end
        if (!aborted && !s.exp_hit && mem_reads - reads_before != WORDS_PER_LINE) begin
            report_mismatch("memory reads on miss", WORDS_PER_LINE, mem_reads - reads_before);
        end
    endtask

    // After a flush every line is back in memory.
    task automatic flush_and_compare();
        int cycles;
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        wait_signal(SIG_BUSY, 1'b1, "busy rising", cycles);
        wait_signal(SIG_BUSY, 1'b0, "busy falling", cycles);
        for (int i = 0; i < MEM_WORDS && !aborted; i++) begin
            if (mem_model[i] !== shadow[i]) begin
                report_mismatch($sformatf("memory word %h", i), shadow[i], mem_model[i]);
            end
        end
    endtask

    initial begin
        arst_n        = 1'b0;
        flush         = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        mem_ready     = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = {16'(i), 16'(i)};
            shadow[i]    = {16'(i), 16'(i)};
        end
        // Set 0 basics, then three tags in set 2, then flush.
        stim_q.push_back(make_stim(OP_READ,  16'h0000, 32'h0, 4'h0, 1'b0));
        stim_q.push_back(make_stim(OP_READ,  16'h0004, 32'h0, 4'h0, 1'b1));
        stim_q.push_back(make_stim(OP_WRITE, 16'h0008, 32'hA5A5_1234, 4'b0011, 1'b1));
        stim_q.push_back(make_stim(OP_WRITE, 16'h0008, 32'hDEAD_BEEF, 4'b1100, 1'b1));
        stim_q.push_back(make_stim(OP_READ,  16'h0008, 32'h0, 4'h0, 1'b1));
        stim_q.push_back(make_stim(OP_READ,  16'h0010, 32'h0, 4'h0, 1'b0));
        stim_q.push_back(make_stim(OP_WRITE, 16'h0020, 32'h1111_0001, 4'b1111, 1'b0));
        stim_q.push_back(make_stim(OP_WRITE, 16'h00A4, 32'h2222_0002, 4'b1111, 1'b0));
        stim_q.push_back(make_stim(OP_WRITE, 16'h012C, 32'h3333_0003, 4'b0101, 1'b0));
        stim_q.push_back(make_stim(OP_READ,  16'h0020, 32'h0, 4'h0, 1'b0));
        stim_q.push_back(make_stim(OP_READ,  16'h00A4, 32'h0, 4'h0, 1'b0));
        stim_q.push_back(make_stim(OP_READ,  16'h012C, 32'h0, 4'h0, 1'b0));
        stim_q.push_back(make_stim(OP_READ,  16'h00A4, 32'h0, 4'h0, 1'b1));
        stim_q.push_back(make_stim(OP_WRITE, 16'h0004, 32'h7700_0000, 4'b1000, 1'b1));
        stim_q.push_back(make_stim(OP_FLUSH, 16'h0000, 32'h0, 4'h0, 1'b0));
        stim_q.push_back(make_stim(OP_READ,  16'h0004, 32'h0, 4'h0, 1'b0));
        stim_q.push_back(make_stim(OP_READ,  16'h0000, 32'h0, 4'h0, 1'b1));
        stim_q.push_back(make_stim(OP_READ,  16'h1F3C, 32'h0, 4'h0, 1'b0));

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        if (req_ready !== 1'b1) begin
            report_mismatch("req_ready", 1, req_ready);
        end
        if (busy !== 1'b0) begin
            report_mismatch("busy", 0, busy);
        end
        if (rsp_valid !== 1'b0) begin
            report_mismatch("rsp_valid", 0, rsp_valid);
        end
        if (mem_req_valid !== 1'b0) begin
            report_mismatch("mem_req_valid", 0, mem_req_valid);
        end

        foreach (stim_q[i]) begin
            if (!aborted && stim_q[i].op == OP_FLUSH) begin
                flush_and_compare();
            end else if (!aborted) begin
                access_and_check(stim_q[i]);
            end
        end

        repeat (2) @(posedge clk);
        if (!aborted && rsp_count != reads_issued) begin
            report_mismatch("rsp_valid pulses", reads_issued, rsp_count);
        end
        $display("Summary: %0d value errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, dut.u_controller.u_properties.failures);
        if (errors == 0 && timeouts == 0 && dut.u_controller.u_properties.failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: tb.f
src/cache_pkg.sv
src/cache_access_buffer.sv
src/cache_way.sv
src/cache_way_select.sv
src/cache_controller.sv
src/cache_top.sv
verif/cache_properties.sv
verif/cache_tb.sv
